/* design/bp_pkg.sv */
`default_nettype none

package bp_pkg;

   // --------------------------------------------------
   // fixed-width types
   // --------------------------------------------------

   // halfword pc, bit 0 never carried
   typedef logic [31:1] pc_t;

   // branch target offset in halfwords
   typedef logic signed [11:0] toffset_t;

   // 2-bit history counter: [1] direction, [0] strength
   typedef logic [1:0] hist_t;

   // --------------------------------------------------
   // default sizing, overridden from the top level
   // --------------------------------------------------

   // btb set index width (16 sets)
   localparam int BTB_INDEX_W_DEF = 4;

   // hashed tag width
   localparam int BTB_TAG_W_DEF = 5;

   // global history length, no wider than the index
   localparam int GHR_W_DEF = 4;

   // return stack entries
   localparam int RAS_DEPTH_DEF = 4;

endpackage

`default_nettype wire

/* design/bp_btb.sv */
`timescale 1ns/1ns
`default_nettype none

module bp_btb
   import bp_pkg::*;
#(
   parameter int BTB_INDEX_W = BTB_INDEX_W_DEF,
   parameter int BTB_TAG_W   = BTB_TAG_W_DEF
) (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire logic                   fetch_req,
   input  wire pc_t                    fetch_addr,
   input  wire logic                   mp_valid,
   input  wire logic                   mp_ataken,
   input  wire logic                   mp_way,
   input  wire toffset_t               mp_toffset,
   input  wire logic                   mp_pc4,
   input  wire logic                   mp_boffset,
   input  wire logic                   mp_call,
   input  wire logic                   mp_ret,
   input  wire logic                   mp_ja,
   input  wire logic [BTB_INDEX_W-1:0] mp_index,
   input  wire logic [BTB_TAG_W-1:0]   mp_btag,
   output logic [BTB_INDEX_W-1:0]      btb_index,
   output logic                        hit,
   output logic                        hit_way,
   output logic                        lru_way,
   output toffset_t                    entry_toffset,
   output logic                        entry_pc4,
   output logic                        entry_boffset,
   output logic                        entry_call,
   output logic                        entry_ret
);

   localparam int NSETS  = 1 << BTB_INDEX_W;
   localparam int TAG_LO = 2 + BTB_INDEX_W;

   logic [BTB_TAG_W-1:0] rd_tag;
   logic [1:0]           match;
   logic                 wr_en;

   // storage, indexed [way][set]
   logic                 valid_q   [2][NSETS];
   logic [BTB_TAG_W-1:0] tag_q     [2][NSETS];
   toffset_t             toffset_q [2][NSETS];
   logic                 pc4_q     [2][NSETS];
   logic                 boffset_q [2][NSETS];
   logic                 call_q    [2][NSETS];
   logic                 ret_q     [2][NSETS];
   logic [NSETS-1:0]     lru_q;    // 1 selects way 1 for replacement

   // --------------------------------------------------
   // hash and read
   // --------------------------------------------------
   assign btb_index = fetch_addr[2 +: BTB_INDEX_W] ^
                      fetch_addr[2 + BTB_INDEX_W +: BTB_INDEX_W] ^
                      fetch_addr[2 + 2*BTB_INDEX_W +: BTB_INDEX_W];

   assign rd_tag = fetch_addr[TAG_LO +: BTB_TAG_W] ^
                   fetch_addr[TAG_LO + BTB_TAG_W +: BTB_TAG_W] ^
                   fetch_addr[TAG_LO + 2*BTB_TAG_W +: BTB_TAG_W];

   always_comb begin
      for (int w = 0; w < 2; w++) begin
         match[w] = fetch_req & valid_q[w][btb_index] & (tag_q[w][btb_index] == rd_tag);
      end
   end

   assign hit     = |match;
   assign hit_way = match[1];     // way 1 wins a double hit
   assign lru_way = lru_q[btb_index];

   // entry of the selected way
   assign entry_toffset = toffset_q[hit_way][btb_index];
   assign entry_pc4     = pc4_q[hit_way][btb_index];
   assign entry_boffset = boffset_q[hit_way][btb_index];
   assign entry_call    = call_q[hit_way][btb_index];
   assign entry_ret     = ret_q[hit_way][btb_index];

   // --------------------------------------------------
   // write from the mispredict packet
   // --------------------------------------------------
   assign wr_en = mp_valid & mp_ataken;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < NSETS; s++) begin
               valid_q[w][s] <= 1'b0;
            end
         end
      end else if (wr_en) begin
         valid_q[mp_way][mp_index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         tag_q[mp_way][mp_index]     <= mp_btag;
         toffset_q[mp_way][mp_index] <= mp_toffset;
         pc4_q[mp_way][mp_index]     <= mp_pc4;
         boffset_q[mp_way][mp_index] <= mp_boffset;
         call_q[mp_way][mp_index]    <= mp_call | mp_ja;  // jal treated as call and ret
         ret_q[mp_way][mp_index]     <= mp_ret | mp_ja;
      end
   end

   // lru, mispredict update lands last so it wins
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lru_q <= '0;
      end else begin
         if (hit) lru_q[btb_index] <= ~hit_way;    // point at the way that missed
         if (wr_en) lru_q[mp_index] <= ~mp_way;
      end
   end

endmodule

`default_nettype wire

/* design/bp_bht.sv */
`timescale 1ns/1ns
`default_nettype none

module bp_bht
   import bp_pkg::*;
#(
   parameter int BTB_INDEX_W = BTB_INDEX_W_DEF,
   parameter int GHR_W       = GHR_W_DEF
) (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire logic [BTB_INDEX_W-1:0] btb_index,
   input  wire logic [GHR_W-1:0]       ghr,
   input  wire logic                   mp_valid,
   input  wire logic                   mp_call,
   input  wire logic                   mp_ret,
   input  wire logic                   mp_ja,
   input  wire logic [BTB_INDEX_W-1:0] mp_index,
   input  wire logic [GHR_W-1:0]       mp_eghr,
   input  wire hist_t                  mp_hist,
   input  wire logic                   br_valid,
   input  wire logic [BTB_INDEX_W-1:0] br_index,
   input  wire logic [GHR_W-1:0]       br_fghr,
   input  wire hist_t                  br_hist,
   output hist_t                       counter
);

   localparam int NENT = 1 << BTB_INDEX_W;

   hist_t                  cnt_q [NENT];
   logic [BTB_INDEX_W-1:0] rd_addr;
   logic [BTB_INDEX_W-1:0] mp_addr;
   logic [BTB_INDEX_W-1:0] br_addr;
   logic                   mp_wr;

   // --------------------------------------------------
   // index hashing, history folded into the low bits
   // --------------------------------------------------
   assign rd_addr = btb_index ^ BTB_INDEX_W'(ghr);
   assign mp_addr = mp_index ^ BTB_INDEX_W'(mp_eghr);   // execute-time history
   assign br_addr = br_index ^ BTB_INDEX_W'(br_fghr);

   // calls, rets and jumps never train the counters
   assign mp_wr = mp_valid & ~mp_call & ~mp_ret & ~mp_ja;

   assign counter = cnt_q[rd_addr];

   // commit port written last so it wins on a shared address
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NENT; i++) begin
            cnt_q[i] <= '0;
         end
      end else begin
         if (mp_wr) begin
            cnt_q[mp_addr] <= mp_hist;
         end
         if (br_valid) begin
            cnt_q[br_addr] <= br_hist;
         end
      end
   end

endmodule

`default_nettype wire

/* design/bp_ghr.sv */
`timescale 1ns/1ns
`default_nettype none

module bp_ghr
   import bp_pkg::*;
#(
   parameter int GHR_W = GHR_W_DEF
) (
   input  wire logic             clk,
   input  wire logic             rst_n,
   input  wire logic             fetch_req,
   input  wire logic             ic_hit,
   input  wire logic             hit,
   input  wire logic             fetch_dir,
   input  wire logic             flush,
   input  wire logic [GHR_W-1:0] mp_fghr,
   output logic [GHR_W-1:0]      ghr
);

   logic advance;

   // only a fetch that returned data and found a branch moves history
   assign advance = fetch_req & ic_hit & hit;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ghr <= '0;
      end else if (flush) begin
         ghr <= mp_fghr;                              // restore from mispredict
      end else if (advance) begin
         ghr <= (ghr << 1) | GHR_W'(fetch_dir);       // newest bit at 0
      end
   end

endmodule

`default_nettype wire

/* design/bp_ret_stack.sv */
`timescale 1ns/1ns
`default_nettype none

module bp_ret_stack
   import bp_pkg::*;
#(
   parameter int RAS_DEPTH = RAS_DEPTH_DEF
) (
   input  wire logic clk,
   input  wire logic rst_n,
   input  wire logic rs_push,
   input  wire logic rs_pop,
   input  wire pc_t  rs_ret_addr,
   output pc_t       rs_top,
   output logic      rs_top_valid
);

   pc_t                  addr_q [RAS_DEPTH];
   logic [RAS_DEPTH-1:0] valid_q;              // entry 0 is the top

   // --------------------------------------------------
   // push shifts down, pop shifts up
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < RAS_DEPTH; i++) begin
            addr_q[i] <= '0;
         end
         valid_q <= '0;
      end else if (rs_push) begin
         for (int i = RAS_DEPTH - 1; i > 0; i--) begin
            addr_q[i] <= addr_q[i-1];   // bottom entry falls off
         end
         addr_q[0] <= rs_ret_addr;
         valid_q   <= {valid_q[RAS_DEPTH-2:0], 1'b1};
      end else if (rs_pop) begin
         for (int i = 0; i < RAS_DEPTH - 1; i++) begin
            addr_q[i] <= addr_q[i+1];
         end
         addr_q[RAS_DEPTH-1] <= '0;
         valid_q             <= {1'b0, valid_q[RAS_DEPTH-1:1]};   // bottom refills invalid
      end
   end

   assign rs_top       = addr_q[0];
   assign rs_top_valid = valid_q[0];

endmodule

`default_nettype wire

/* design/bp_predict.sv */
`timescale 1ns/1ns
`default_nettype none

module bp_predict
   import bp_pkg::*;
(
   input  wire logic     fetch_req,
   input  wire pc_t      fetch_addr,
   input  wire logic     bpred_disable,
   input  wire logic     hit,
   input  wire logic     hit_way,
   input  wire logic     lru_way,
   input  wire toffset_t entry_toffset,
   input  wire logic     entry_pc4,
   input  wire logic     entry_boffset,
   input  wire logic     entry_call,
   input  wire logic     entry_ret,
   input  wire hist_t    counter,
   input  wire pc_t      rs_top,
   input  wire logic     rs_top_valid,
   output logic          hit_taken,
   output pc_t           target,
   output logic          fetch_dir,
   output logic          way,
   output logic          valid,
   output logic          hist1,
   output logic          hist0,
   output logic          pc4,
   output logic          ret,
   output toffset_t      poffset,
   output logic          rs_push,
   output logic          rs_pop,
   output pc_t           rs_ret_addr
);

   pc_t  branch_pc;
   pc_t  offset_ext;
   pc_t  adder_target;
   logic force_taken;
   logic use_rs;

   // calls and rets always go taken regardless of the counter
   assign force_taken = entry_call | entry_ret;
   assign fetch_dir   = hit & (counter[1] | force_taken);
   assign hit_taken   = fetch_dir & fetch_req & ~bpred_disable;

   // --------------------------------------------------
   // target and return address
   // --------------------------------------------------
   assign branch_pc    = {fetch_addr[31:2], entry_boffset};
   assign offset_ext   = {{19{entry_toffset[11]}}, entry_toffset};
   assign adder_target = branch_pc + offset_ext;

   assign use_rs = entry_ret & ~entry_call & rs_top_valid;
   assign target = use_rs ? rs_top : adder_target;

   assign rs_ret_addr = branch_pc + (entry_pc4 ? 31'd2 : 31'd1);   // next inst
   assign rs_push     = entry_call & ~entry_ret & hit_taken;
   assign rs_pop      = entry_ret & ~entry_call & hit_taken;

   // fetch-side outputs
   assign way     = hit ? hit_way : lru_way;
   assign valid   = hit & ~bpred_disable;
   assign hist1   = counter[1] | force_taken;
   assign hist0   = counter[0];
   assign pc4     = hit & entry_pc4;
   assign ret     = hit & entry_ret & ~entry_call;
   assign poffset = entry_toffset;

endmodule

`default_nettype wire

/* design/bp_top.sv */
`timescale 1ns/1ns
`default_nettype none

module bp_top
   import bp_pkg::*;
#(
   parameter int BTB_INDEX_W = BTB_INDEX_W_DEF,
   parameter int BTB_TAG_W   = BTB_TAG_W_DEF,
   parameter int GHR_W       = GHR_W_DEF,
   parameter int RAS_DEPTH   = RAS_DEPTH_DEF
) (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   // fetch
   input  wire logic                   fetch_req,
   input  wire pc_t                    fetch_addr,
   input  wire logic                   ic_hit,
   // mispredict packet
   input  wire logic                   mp_valid,
   input  wire logic                   mp_ataken,
   input  wire logic                   mp_way,
   input  wire hist_t                  mp_hist,
   input  wire toffset_t               mp_toffset,
   input  wire logic                   mp_pc4,
   input  wire logic                   mp_boffset,
   input  wire logic                   mp_call,
   input  wire logic                   mp_ret,
   input  wire logic                   mp_ja,
   input  wire logic [BTB_INDEX_W-1:0] mp_index,
   input  wire logic [BTB_TAG_W-1:0]   mp_btag,
   input  wire logic [GHR_W-1:0]       mp_eghr,
   input  wire logic [GHR_W-1:0]       mp_fghr,
   // commit history update
   input  wire logic                   br_valid,
   input  wire hist_t                  br_hist,
   input  wire logic [BTB_INDEX_W-1:0] br_index,
   input  wire logic [GHR_W-1:0]       br_fghr,
   input  wire logic                   flush,
   input  wire logic                   bpred_disable,
   // prediction
   output logic                        hit_taken,
   output pc_t                         target,
   output toffset_t                    poffset,
   output logic                        valid,
   output logic                        way,
   output logic                        hist1,
   output logic                        hist0,
   output logic                        pc4,
   output logic                        ret,
   output logic [GHR_W-1:0]            fghr
);

   logic [BTB_INDEX_W-1:0] btb_index;
   logic                   hit, hit_way, lru_way;
   toffset_t               entry_toffset;
   logic                   entry_pc4, entry_boffset, entry_call, entry_ret;
   hist_t                  counter;
   logic                   fetch_dir;
   logic                   rs_push, rs_pop, rs_top_valid;
   pc_t                    rs_ret_addr, rs_top;

   // --------------------------------------------------
   // lookup path: btb, bht, predict
   // --------------------------------------------------
   bp_btb #(.BTB_INDEX_W(BTB_INDEX_W), .BTB_TAG_W(BTB_TAG_W)) u_btb (
      .clk, .rst_n, .fetch_req, .fetch_addr,
      .mp_valid, .mp_ataken, .mp_way, .mp_toffset, .mp_pc4, .mp_boffset,
      .mp_call, .mp_ret, .mp_ja, .mp_index, .mp_btag,
      .btb_index, .hit, .hit_way, .lru_way, .entry_toffset, .entry_pc4,
      .entry_boffset, .entry_call, .entry_ret
   );

   bp_bht #(.BTB_INDEX_W(BTB_INDEX_W), .GHR_W(GHR_W)) u_bht (
      .clk, .rst_n, .btb_index, .ghr(fghr),
      .mp_valid, .mp_call, .mp_ret, .mp_ja, .mp_index, .mp_eghr, .mp_hist,
      .br_valid, .br_index, .br_fghr, .br_hist, .counter
   );

   bp_predict u_predict (
      .fetch_req, .fetch_addr, .bpred_disable, .hit, .hit_way, .lru_way,
      .entry_toffset, .entry_pc4, .entry_boffset, .entry_call, .entry_ret,
      .counter, .rs_top, .rs_top_valid,
      .hit_taken, .target, .fetch_dir, .way, .valid, .hist1, .hist0, .pc4,
      .ret, .poffset, .rs_push, .rs_pop, .rs_ret_addr
   );

   // history and return stack state
   bp_ghr #(.GHR_W(GHR_W)) u_ghr (
      .clk, .rst_n, .fetch_req, .ic_hit, .hit, .fetch_dir, .flush, .mp_fghr,
      .ghr(fghr)
   );

   bp_ret_stack #(.RAS_DEPTH(RAS_DEPTH)) u_ret_stack (
      .clk, .rst_n, .rs_push, .rs_pop, .rs_ret_addr, .rs_top, .rs_top_valid
   );

endmodule

`default_nettype wire

/* tests/bp_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module bp_tb
   import bp_pkg::*;
();

   localparam int IW = 4;
   localparam int TW = 5;
   localparam int GW = 4;
   localparam int RD = 4;
   localparam int NSETS = 1 << IW;
   localparam int RESET_CYCLES = 16;
   localparam int N_TESTS = 6;
   localparam int CYCLES_PER_TEST = 16;   // longest test takes about 8
   localparam int MAX_CYCLES = RESET_CYCLES + N_TESTS * CYCLES_PER_TEST + 16;

   logic clk = 1'b0;
   logic rst_n, fetch_req, ic_hit, flush, bpred_disable;
   pc_t fetch_addr;
   logic mp_valid, mp_ataken, mp_way, mp_pc4, mp_boffset, mp_call, mp_ret, mp_ja;
   hist_t mp_hist, br_hist;
   toffset_t mp_toffset;
   logic [IW-1:0] mp_index, br_index;
   logic [TW-1:0] mp_btag;
   logic [GW-1:0] mp_eghr, mp_fghr, br_fghr;
   logic br_valid;
   logic hit_taken, valid, way, hist1, hist0, pc4, ret;
   pc_t target;
   toffset_t poffset;
   logic [GW-1:0] fghr;

   // reference model state
   logic btb_v [2][NSETS], btb_pc4 [2][NSETS], btb_boff [2][NSETS];
   logic btb_call [2][NSETS], btb_ret [2][NSETS];
   logic [TW-1:0] btb_tag [2][NSETS];
   toffset_t btb_off [2][NSETS];
   logic [NSETS-1:0] lru_m;
   hist_t cnt_m [NSETS];
   logic [GW-1:0] ghr_m;
   pc_t stk_addr [RD];
   logic stk_v [RD];

   // expected values of the current lookup
   logic [IW-1:0] x_idx;
   logic x_hit, x_hw, x_call, x_retf, x_dir, x_taken, x_valid, x_way, x_pc4, x_ret;
   hist_t x_cnt;
   toffset_t x_off;
   pc_t x_bpc, x_target, x_raddr;

   string test_name;
   int n_checks = 0;
   int n_errors = 0;
   int cycle_cnt = 0;

   bp_top #(.BTB_INDEX_W(IW), .BTB_TAG_W(TW), .GHR_W(GW), .RAS_DEPTH(RD)) dut (
      .clk, .rst_n, .fetch_req, .fetch_addr, .ic_hit,
      .mp_valid, .mp_ataken, .mp_way, .mp_hist, .mp_toffset, .mp_pc4, .mp_boffset,
      .mp_call, .mp_ret, .mp_ja, .mp_index, .mp_btag, .mp_eghr, .mp_fghr,
      .br_valid, .br_hist, .br_index, .br_fghr, .flush, .bpred_disable,
      .hit_taken, .target, .poffset, .valid, .way, .hist1, .hist0, .pc4, .ret, .fghr
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == MAX_CYCLES) begin
         $display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
         $display(">>> FAIL");
         $finish;
      end
   end

   // --------------------------------------------------
   // hash rules and model
   // --------------------------------------------------
   function automatic logic [IW-1:0] hash_index(input pc_t a);
      return a[2 +: IW] ^ a[2+IW +: IW] ^ a[2+2*IW +: IW];
   endfunction

   function automatic logic [TW-1:0] hash_tag(input pc_t a);
      return a[2+IW +: TW] ^ a[2+IW+TW +: TW] ^ a[2+IW+2*TW +: TW];
   endfunction

   task automatic predict_expected(input pc_t a);
      logic [TW-1:0] tg;
      logic m0;
      logic m1;
      x_idx    = hash_index(a);
      tg       = hash_tag(a);
      m0       = btb_v[0][x_idx] && (btb_tag[0][x_idx] == tg);
      m1       = btb_v[1][x_idx] && (btb_tag[1][x_idx] == tg);
      x_hit    = m0 | m1;
      x_hw     = m1;
      x_cnt    = cnt_m[x_idx ^ ghr_m];
      x_call   = x_hit & btb_call[x_hw][x_idx];
      x_retf   = x_hit & btb_ret[x_hw][x_idx];
      x_off    = btb_off[x_hw][x_idx];
      x_dir    = x_hit & (x_cnt[1] | x_call | x_retf);
      x_taken  = x_dir & ~bpred_disable;
      x_valid  = x_hit & ~bpred_disable;
      x_way    = x_hit ? x_hw : lru_m[x_idx];
      x_pc4    = x_hit & btb_pc4[x_hw][x_idx];
      x_ret    = x_retf & ~x_call;
      x_bpc    = {a[31:2], btb_boff[x_hw][x_idx]};
      x_target = x_bpc + pc_t'(int'(x_off));   // offset counts halfwords
      if (x_ret && stk_v[0]) x_target = stk_addr[0];
      x_raddr  = x_bpc + (btb_pc4[x_hw][x_idx] ? 31'd2 : 31'd1);
   endtask

   // state change caused by the lookup just checked
   task automatic advance_model(input logic ich);
      if (x_hit) lru_m[x_idx] = ~x_hw;
      if (ich && x_hit) ghr_m = {ghr_m[GW-2:0], x_dir};
      if (x_taken && x_call && !x_retf) begin
         for (int i = RD - 1; i > 0; i--) begin
            stk_addr[i] = stk_addr[i-1];
            stk_v[i]    = stk_v[i-1];
         end
         stk_addr[0] = x_raddr;
         stk_v[0]    = 1'b1;
      end else if (x_taken && x_ret) begin
         for (int i = 0; i < RD - 1; i++) begin
            stk_addr[i] = stk_addr[i+1];
            stk_v[i]    = stk_v[i+1];
         end
         stk_v[RD-1] = 1'b0;
      end
   endtask

   // --------------------------------------------------
   // drive and check
   // --------------------------------------------------
   task automatic compare_value(input string field, input logic [31:0] expected,
                                input logic [31:0] actual);
      n_checks++;
      if (actual !== expected) begin
         n_errors++;
         $display("MISMATCH %s %s: expected %h, actual %h",
                  test_name, field, expected, actual);
      end
   endtask

   task automatic clear_strobes();
      fetch_req <= 1'b0;
      ic_hit    <= 1'b0;
      mp_valid  <= 1'b0;
      br_valid  <= 1'b0;
      flush     <= 1'b0;
   endtask

   task automatic fetch_and_check(input pc_t a, input logic ich);
      @(posedge clk);
      clear_strobes();
      fetch_req  <= 1'b1;
      fetch_addr <= a;
      ic_hit     <= ich;
      @(negedge clk);   // outputs settled
      predict_expected(a);
      compare_value("valid", x_valid, valid);
      compare_value("hit_taken", x_taken, hit_taken);
      compare_value("way", x_way, way);
      compare_value("pc4", x_pc4, pc4);
      compare_value("ret", x_ret, ret);
      compare_value("fghr", ghr_m, fghr);
      if (x_hit) begin
         compare_value("poffset", x_off, poffset);
         compare_value("target", x_target, target);
         compare_value("hist1", x_cnt[1] | x_call | x_retf, hist1);
         compare_value("hist0", x_cnt[0], hist0);
      end
      advance_model(ich);
   endtask

   task automatic install_branch(input pc_t a, input logic w, input toffset_t off,
                                 input logic p4, input logic bo, input logic cl,
                                 input logic rt, input hist_t h);
      logic [IW-1:0] idx;
      idx = hash_index(a);
      @(posedge clk);
      clear_strobes();
      mp_valid   <= 1'b1;
      mp_ataken  <= 1'b1;
      mp_way     <= w;
      mp_hist    <= h;
      mp_toffset <= off;
      mp_pc4     <= p4;
      mp_boffset <= bo;
      mp_call    <= cl;
      mp_ret     <= rt;
      mp_ja      <= 1'b0;
      mp_index   <= idx;
      mp_btag    <= hash_tag(a);
      mp_eghr    <= ghr_m;
      btb_v[w][idx]    = 1'b1;
      btb_tag[w][idx]  = hash_tag(a);
      btb_off[w][idx]  = off;
      btb_pc4[w][idx]  = p4;
      btb_boff[w][idx] = bo;
      btb_call[w][idx] = cl;
      btb_ret[w][idx]  = rt;
      lru_m[idx]       = ~w;
      if (!cl && !rt) cnt_m[idx ^ ghr_m] = h;
   endtask

   task automatic write_counters(input logic mp_en, input logic [IW-1:0] m_idx,
                                 input logic [GW-1:0] m_ghr, input hist_t m_h,
                                 input logic br_en, input logic [IW-1:0] b_idx,
                                 input logic [GW-1:0] b_ghr, input hist_t b_h);
      @(posedge clk);
      clear_strobes();
      mp_valid  <= mp_en;
      mp_ataken <= 1'b0;
      mp_call   <= 1'b0;
      mp_ret    <= 1'b0;
      mp_ja     <= 1'b0;
      mp_index  <= m_idx;
      mp_eghr   <= m_ghr;
      mp_hist   <= m_h;
      br_valid  <= br_en;
      br_index  <= b_idx;
      br_fghr   <= b_ghr;
      br_hist   <= b_h;
      if (mp_en) cnt_m[m_idx ^ m_ghr] = m_h;
      if (br_en) cnt_m[b_idx ^ b_ghr] = b_h;   // commit lands last
   endtask

   task automatic restore_history(input logic [GW-1:0] v);
      @(posedge clk);
      clear_strobes();
      flush   <= 1'b1;
      mp_fghr <= v;
      ghr_m   = v;
   endtask

   task automatic set_disable(input logic v);
      @(posedge clk);
      clear_strobes();
      bpred_disable <= v;
   endtask

   // --------------------------------------------------
   // directed tests
   // --------------------------------------------------
   pc_t addr_a;

   task automatic after_reset_check();
      test_name = "after_reset";
      for (int i = 0; i < 8; i++) begin
         fetch_and_check(pc_t'($urandom()), 1'b1);
      end
   endtask

   task automatic install_and_train();
      test_name = "install_train";
      addr_a = pc_t'($urandom());
      install_branch(addr_a, lru_m[hash_index(addr_a)], -12'sd40, 1'b1, 1'b1, 1'b0, 1'b0,
                     2'b01);
      fetch_and_check(addr_a, 1'b0);
      write_counters(1'b0, '0, '0, 2'b00, 1'b1, hash_index(addr_a), ghr_m, 2'b11);
      fetch_and_check(addr_a, 1'b0);
      set_disable(1'b1);
      fetch_and_check(addr_a, 1'b0);
      set_disable(1'b0);
   endtask

   task automatic history_update();
      test_name = "ghr";
      fetch_and_check(addr_a, 1'b1);                // taken, shifts in a one
      fetch_and_check(pc_t'($urandom()), 1'b1);
      fetch_and_check(pc_t'($urandom()), 1'b1);     // miss above held it
      restore_history(4'b1010);
      fetch_and_check(pc_t'($urandom()), 1'b0);
      restore_history(4'b0000);
   endtask

   task automatic bht_write_priority();
      logic [IW-1:0] idx;
      test_name = "bht_priority";
      idx = hash_index(addr_a);
      // both ports hash to the same entry by different routes
      write_counters(1'b1, idx ^ 4'd3, ghr_m ^ 4'd3, 2'b01, 1'b1, idx, ghr_m, 2'b10);
      fetch_and_check(addr_a, 1'b0);
   endtask

   task automatic call_return();
      pc_t c;
      pc_t r;
      test_name = "call_return";
      c = pc_t'($urandom());
      r = pc_t'($urandom());
      install_branch(c, lru_m[hash_index(c)], 12'sd128, 1'b0, 1'b0, 1'b1, 1'b0, 2'b00);
      fetch_and_check(c, 1'b0);                     // pushes return address
      install_branch(r, lru_m[hash_index(r)], -12'sd100, 1'b1, 1'b0, 1'b0, 1'b1, 2'b00);
      fetch_and_check(r, 1'b0);
      fetch_and_check(r, 1'b0);                     // stack empty now
   endtask

   task automatic lru_replacement();
      pc_t p;
      pc_t q;
      pc_t flip;
      int  tries;
      test_name = "lru";
      tries = 0;
      p = pc_t'($urandom());
      while ((btb_v[0][hash_index(p)] || btb_v[1][hash_index(p)]) && tries < 32) begin
         p = pc_t'($urandom());
         tries++;
      end
      flip = '0;
      flip[2] = 1'b1;
      flip[2+IW] = 1'b1;   // same set, tag differs
      q = p ^ flip;
      install_branch(p, lru_m[hash_index(p)], 12'sd6, 1'b0, 1'b0, 1'b0, 1'b0, 2'b00);
      fetch_and_check(q, 1'b0);
      install_branch(q, lru_m[hash_index(q)], 12'sd10, 1'b1, 1'b1, 1'b0, 1'b0, 2'b11);
      fetch_and_check(p, 1'b0);
      fetch_and_check(q, 1'b0);
   endtask

   initial begin
      void'($urandom(32'h992));
      rst_n <= 1'b0;
      clear_strobes();
      bpred_disable <= 1'b0;
      fetch_addr <= '0;
      {mp_ataken, mp_way, mp_pc4, mp_boffset, mp_call, mp_ret, mp_ja} <= '0;
      {mp_hist, br_hist, mp_toffset, mp_index, br_index, mp_btag} <= '0;
      {mp_eghr, mp_fghr, br_fghr} <= '0;
      for (int s = 0; s < NSETS; s++) begin
         for (int w = 0; w < 2; w++) begin
            {btb_v[w][s], btb_pc4[w][s], btb_boff[w][s], btb_call[w][s]} = '0;
            {btb_ret[w][s], btb_tag[w][s], btb_off[w][s]} = '0;
         end
         cnt_m[s] = '0;
      end
      for (int i = 0; i < RD; i++) begin
         stk_addr[i] = '0;
         stk_v[i]    = 1'b0;
      end
      lru_m = '0;
      ghr_m = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      after_reset_check();
      install_and_train();
      history_update();
      bht_write_priority();
      call_return();
      lru_replacement();
      $display("checks: %0d  errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
design/bp_pkg.sv
design/bp_btb.sv
design/bp_bht.sv
design/bp_ghr.sv
design/bp_ret_stack.sv
design/bp_predict.sv
design/bp_top.sv
tests/bp_tb.sv

/* Bender.yml */
package:
  name: bp

sources:
  - design/bp_pkg.sv
  - design/bp_btb.sv
  - design/bp_bht.sv
  - design/bp_ghr.sv
  - design/bp_ret_stack.sv
  - design/bp_predict.sv
  - design/bp_top.sv
  - target: test
    files:
      - tests/bp_tb.sv
